// File: bench/exec_properties.sv
`timescale 1ns/1ns

module exec_properties
  import exec_pkg::*, cb_pkg::*;
(
  input logic     CLK,
  input logic     nRST,
  input logic     wb_valid,
  input logic     wb_ready,
  input cb_idx_t  wb_index,
  input reg_idx_t wb_rd,
  input word_t    wb_wdata,
  input logic     wb_wen,
  input exc_e     wb_exception
);

  // payload held while the completion buffer stalls
  property p_stall_stable;
    @(posedge CLK) disable iff (!nRST)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb_index) && $stable(wb_rd) &&
        $stable(wb_wdata) && $stable(wb_wen) && $stable(wb_exception);
  endproperty

  a_stall_stable: assert property (p_stall_stable)
    else $error("writeback payload changed while stalled");

  // an exception never writes a register
  a_exc_no_wen: assert property (@(posedge CLK) disable iff (!nRST)
    wb_valid && (wb_exception == ILLEGAL) |-> !wb_wen)
    else $error("register write enabled on an exception");

  // nothing leaves in the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !wb_valid)
    else $error("wb_valid high right after reset release");

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 10
) (
  output logic CLK
);

  // free-running clock that starts low
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

endmodule

// File: bench/tb_exec.sv
`timescale 1ns/1ns

module tb_exec
  import exec_pkg::*, cb_pkg::*;
();

  localparam int NUM_LANES   = 2;
  localparam int LANE_DEPTH  = 3;
  localparam int NUM_ENTRIES = 26;
  localparam int DRAIN_LIMIT = 100;

  logic     CLK;
  logic     nRST;
  logic     in_valid;
  logic     in_ready;
  word_t    in_insn;
  word_t    in_rs1;
  word_t    in_rs2;
  word_t    in_pc;
  reg_idx_t in_rd;
  cb_idx_t  in_index;
  logic     wb_valid;
  logic     wb_ready;
  cb_idx_t  wb_index;
  reg_idx_t wb_rd;
  word_t    wb_wdata;
  logic     wb_wen;
  exc_e     wb_exception;

  // stimulus and expected results
  word_t    tbl_insn  [NUM_ENTRIES];
  word_t    tbl_rs1   [NUM_ENTRIES];
  word_t    tbl_rs2   [NUM_ENTRIES];
  word_t    tbl_pc    [NUM_ENTRIES];
  reg_idx_t tbl_rd    [NUM_ENTRIES];
  word_t    exp_wdata [NUM_ENTRIES];
  logic     exp_wen   [NUM_ENTRIES];
  exc_e     exp_exc   [NUM_ENTRIES];
  int       num_added;

  // scoreboard keyed by completion buffer index
  logic [CB_ENTRIES-1:0] pending;
  int   slot_entry   [CB_ENTRIES];
  int   accept_cycle [CB_ENTRIES];
  int   order_q [$];
  int   outstanding;
  int   checks;
  int   errors;
  int   stall_cycles;
  int   pass_num;
  int   cycle = 0;

  tb_clock #(.PERIOD(10)) u_clock (.CLK(CLK));

  exec_top #(
    .NUM_LANES  (NUM_LANES),
    .LANE_DEPTH (LANE_DEPTH)
  ) dut (.*);

  bind exec_top exec_properties u_properties (
    .CLK (CLK), .nRST (nRST), .wb_valid (wb_valid), .wb_ready (wb_ready),
    .wb_index (wb_index), .wb_rd (wb_rd), .wb_wdata (wb_wdata), .wb_wen (wb_wen),
    .wb_exception (wb_exception)
  );

  always @(posedge CLK) cycle <= cycle + 1;

  function automatic word_t r_type_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input reg_idx_t rd);
    return {funct7, 5'd2, 5'd1, funct3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type_word(input logic [6:0] opcode, input logic [11:0] imm,
                                        input logic [2:0] funct3, input reg_idx_t rd);
    return {imm, 5'd1, funct3, rd, opcode};
  endfunction

  task automatic add_entry(input word_t insn, input word_t rs1, input word_t rs2,
                           input reg_idx_t rd, input word_t wdata);
    tbl_insn[num_added]  = insn;
    tbl_rs1[num_added]   = rs1;
    tbl_rs2[num_added]   = rs2;
    tbl_pc[num_added]    = 32'h0000_1000 + 4 * num_added;
    tbl_rd[num_added]    = rd;
    exp_wdata[num_added] = wdata;
    // x0 is never written
    exp_wen[num_added]   = (rd != 5'd0);
    exp_exc[num_added]   = NO_EXCEPTION;
    num_added++;
  endtask

  // unsupported encodings return their pc
  task automatic add_illegal(input word_t insn, input reg_idx_t rd);
    int n;
    n = num_added;
    add_entry(insn, 32'h5555_5555, 32'haaaa_aaaa, rd, 32'h0);
    exp_wdata[n] = tbl_pc[n];
    exp_wen[n]   = 1'b0;
    exp_exc[n]   = ILLEGAL;
  endtask

  task automatic build_table();
    // register-register ALU
    add_entry(r_type_word(7'h00, 3'd0, 5'd1), 32'h1234, 32'h0f0f, 5'd1, 32'h2143);
    add_entry(r_type_word(7'h20, 3'd0, 5'd2), 32'd5, 32'd7, 5'd2, 32'hfffffffe);
    add_entry(r_type_word(7'h00, 3'd1, 5'd3), 32'hf1, 32'h24, 5'd3, 32'hf10);
    add_entry(r_type_word(7'h00, 3'd2, 5'd4), 32'hffffffff, 32'd1, 5'd4, 32'd1);
    add_entry(r_type_word(7'h00, 3'd3, 5'd5), 32'hffffffff, 32'd1, 5'd5, 32'd0);
    add_entry(r_type_word(7'h00, 3'd4, 5'd6), 32'hff00ff00, 32'h0ff00ff0, 5'd6, 32'hf0f0f0f0);
    add_entry(r_type_word(7'h00, 3'd5, 5'd7), 32'h80000000, 32'd4, 5'd7, 32'h08000000);
    add_entry(r_type_word(7'h20, 3'd5, 5'd8), 32'h80000000, 32'd4, 5'd8, 32'hf8000000);
    add_entry(r_type_word(7'h00, 3'd6, 5'd9), 32'h0f0000f0, 32'h0f0f, 5'd9, 32'h0f000fff);
    add_entry(r_type_word(7'h00, 3'd7, 5'd10), 32'h12345678, 32'h0f0f0f0f, 5'd10, 32'h02040608);
    // register-immediate with rs2 ignored
    add_entry(i_type_word(7'h13, 12'hfff, 3'd0, 5'd11), 32'd10, 32'hdeadbeef, 5'd11, 32'd9);
    add_entry(i_type_word(7'h13, 12'hffb, 3'd2, 5'd12), 32'hfffffff0, 32'hdeadbeef, 5'd12, 32'd1);
    add_entry(i_type_word(7'h13, 12'hfff, 3'd3, 5'd13), 32'd5, 32'hdeadbeef, 5'd13, 32'd1);
    add_entry(i_type_word(7'h13, 12'hfff, 3'd4, 5'd14), 32'h12345678, 32'h0, 5'd14, 32'hedcba987);
    add_entry(i_type_word(7'h13, 12'h800, 3'd6, 5'd15), 32'h12, 32'h0, 5'd15, 32'hfffff812);
    add_entry(i_type_word(7'h13, 12'h008, 3'd1, 5'd16), 32'hab, 32'h0, 5'd16, 32'hab00);
    add_entry(i_type_word(7'h13, 12'h408, 3'd5, 5'd17), 32'hf0000000, 32'h0, 5'd17, 32'hfff00000);
    // low word of the product
    add_entry(r_type_word(7'h01, 3'd0, 5'd18), 32'd7, 32'd6, 5'd18, 32'd42);
    add_entry(r_type_word(7'h01, 3'd0, 5'd19), 32'hfffffffd, 32'd5, 5'd19, 32'hfffffff1);
    add_entry(r_type_word(7'h01, 3'd0, 5'd20), 32'hfffffffc, 32'hfffffffc, 5'd20, 32'd16);
    add_entry(r_type_word(7'h01, 3'd0, 5'd21), 32'h12345678, 32'h10, 5'd21, 32'h23456780);
    add_illegal(r_type_word(7'h7f, 3'd0, 5'd22), 5'd22);
    add_illegal(i_type_word(7'h13, 12'h401, 3'd1, 5'd23), 5'd23);
    add_illegal(r_type_word(7'h01, 3'd1, 5'd24), 5'd24);
    add_illegal(i_type_word(7'h03, 12'h000, 3'd2, 5'd25), 5'd25);
    add_entry(r_type_word(7'h00, 3'd0, 5'd0), 32'd3, 32'd4, 5'd0, 32'd7);
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    if (pass_num == 1) begin
      wb_ready = ($urandom % 2) == 0;
    end else begin
      wb_ready = 1'b1;
    end
  endtask

  task automatic issue_entry(input int n);
    int idx;
    bit accepted;
    idx      = n % CB_ENTRIES;
    in_valid = 1'b1;
    in_insn  = tbl_insn[n];
    in_rs1   = tbl_rs1[n];
    in_rs2   = tbl_rs2[n];
    in_pc    = tbl_pc[n];
    in_rd    = tbl_rd[n];
    in_index = cb_idx_t'(idx);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge CLK);
      if (in_ready) begin
        accepted = 1'b1;
        if (pending[idx]) begin
          $display("index %0d issued again while still outstanding", idx);
          errors++;
        end
        pending[idx]      = 1'b1;
        slot_entry[idx]   = n;
        accept_cycle[idx] = cycle;
        outstanding++;
        if (pass_num == 0) begin
          order_q.push_back(idx);
        end
      end else begin
        stall_cycles++;
      end
      next_cycle();
    end
  endtask

  task automatic check_writeback();
    int idx;
    int n;
    int expected_idx;
    idx = int'(wb_index);
    checks++;
    if (!pending[idx]) begin
      $display("duplicate or unexpected writeback for index %0d at %0t", idx, $time);
      errors++;
      return;
    end
    n            = slot_entry[idx];
    pending[idx] = 1'b0;
    outstanding--;
    if (wb_wdata !== exp_wdata[n] || wb_rd !== tbl_rd[n]) begin
      $display("FAIL %0t: entry %0d wdata %h rd %0d, expected %h rd %0d", $time, n,
               wb_wdata, wb_rd, exp_wdata[n], tbl_rd[n]);
      errors++;
    end
    if (wb_wen !== exp_wen[n] || wb_exception !== exp_exc[n]) begin
      $display("FAIL %0t: entry %0d wen %b exception %b, expected %b %b", $time, n,
               wb_wen, wb_exception, exp_wen[n], exp_exc[n]);
      errors++;
    end
    // fixed latency and issue order only without back-pressure
    if (pass_num == 0) begin
      if (cycle - accept_cycle[idx] != LANE_DEPTH) begin
        $display("FAIL %0t: entry %0d latency %0d cycles, expected %0d", $time, n,
                 cycle - accept_cycle[idx], LANE_DEPTH);
        errors++;
      end
      expected_idx = (order_q.size() != 0) ? order_q.pop_front() : -1;
      if (expected_idx != idx) begin
        $display("FAIL %0t: index %0d out of issue order, expected %0d", $time, idx,
                 expected_idx);
        errors++;
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    for (int i = 0; i < CB_ENTRIES; i++) begin
      if (pending[i]) begin
        $display("missing writeback: index %0d (entry %0d) never returned", i, slot_entry[i]);
        errors++;
        pending[i] = 1'b0;
      end
    end
    outstanding = 0;
  endtask

  always @(negedge CLK) begin
    if (nRST && wb_valid && wb_ready) begin
      check_writeback();
    end
  end

  initial begin
    void'($urandom(32'hc3747312));
    nRST         = 1'b0;
    in_valid     = 1'b0;
    in_insn      = '0;
    in_rs1       = '0;
    in_rs2       = '0;
    in_pc        = '0;
    in_rd        = '0;
    in_index     = '0;
    wb_ready     = 1'b1;
    pending      = '0;
    outstanding  = 0;
    checks       = 0;
    errors       = 0;
    stall_cycles = 0;
    pass_num     = 0;
    num_added    = 0;
    build_table();
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    checks++;
    if (wb_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("FAIL %0t: after reset wb_valid %b in_ready %b", $time, wb_valid, in_ready);
      errors++;
    end
    next_cycle();
    // first pass with wb_ready high, second with random back-pressure
    for (int p = 0; p < 2; p++) begin
      pass_num = p;
      for (int n = 0; n < NUM_ENTRIES; n++) begin
        if (pass_num == 1 && ($urandom % 4) == 0) begin
          in_valid = 1'b0;
          next_cycle();
        end
        issue_entry(n);
      end
      in_valid = 1'b0;
      drain();
    end
    checks++;
    if (stall_cycles == 0) begin
      $display("in_ready never fell while the lanes were under back-pressure");
      errors++;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (NUM_ENTRIES * 20 + 200) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run did not finish", NUM_ENTRIES * 20 + 200);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: logic/cb_pkg.sv
package cb_pkg;

  // completion buffer depth
  localparam int CB_ENTRIES = 16;

  typedef logic [$clog2(CB_ENTRIES)-1:0] cb_idx_t;

  typedef enum logic {
    NO_EXCEPTION = 1'b0,
    ILLEGAL      = 1'b1
  } exc_e;

endpackage

// File: logic/exec_lane.sv
`timescale 1ns/1ns

module exec_lane
  import exec_pkg::*, cb_pkg::*;
#(
  parameter int LANE_DEPTH = 3
) (
  input logic   CLK,
  input logic   nRST,
  issue_if.lane iss,
  result_if.lane res
);

  localparam int LAST = LANE_DEPTH - 1;

  // stage 0 holds the issued operation
  logic     s0_valid;
  alu_op_e  s0_op;
  word_t    s0_a;
  word_t    s0_b;
  word_t    s0_pc;
  reg_idx_t s0_rd;
  cb_idx_t  s0_index;
  logic     s0_illegal;

  word_t    alu_res;
  word_t    mul_res;
  logic     advance;

  // stages 1 to LAST carry the computed results
  logic [LAST:1] valid_q;
  logic [LAST:1] is_mul_q;
  logic [LAST:1] illegal_q;
  word_t         alu_q   [1:LAST];
  word_t         mul_q   [1:LAST];
  word_t         pc_q    [1:LAST];
  reg_idx_t      rd_q    [1:LAST];
  cb_idx_t       index_q [1:LAST];

  // whole lane holds while the last stage waits for a grant
  assign advance   = ~valid_q[LAST] | res.grant;
  assign iss.ready = ~s0_valid | advance;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s0_valid <= 1'b0;
      valid_q  <= '0;
    end else begin
      if (iss.ready) begin
        s0_valid <= iss.valid;
      end
      if (advance) begin
        valid_q[1] <= s0_valid;
        for (int k = 2; k <= LAST; k++) begin
          valid_q[k] <= valid_q[k-1];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (iss.valid && iss.ready) begin
      s0_op      <= iss.op;
      s0_a       <= iss.op_a;
      s0_b       <= iss.op_b;
      s0_pc      <= iss.pc;
      s0_rd      <= iss.rd;
      s0_index   <= iss.index;
      s0_illegal <= iss.illegal;
    end
  end

  always_comb begin
    case (s0_op)
      ALU_ADD:  alu_res = s0_a + s0_b;
      ALU_SUB:  alu_res = s0_a - s0_b;
      ALU_SLL:  alu_res = s0_a << s0_b[4:0];
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(s0_a) < $signed(s0_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, s0_a < s0_b};
      ALU_XOR:  alu_res = s0_a ^ s0_b;
      ALU_SRL:  alu_res = s0_a >> s0_b[4:0];
      ALU_SRA:  alu_res = word_t'($signed(s0_a) >>> s0_b[4:0]);
      ALU_OR:   alu_res = s0_a | s0_b;
      ALU_AND:  alu_res = s0_a & s0_b;
      default:  alu_res = '0;
    endcase
  end

  // low word of the product
  assign mul_res = s0_a * s0_b;

  always_ff @(posedge CLK) begin
    if (advance) begin
      alu_q[1]     <= alu_res;
      mul_q[1]     <= mul_res;
      pc_q[1]      <= s0_pc;
      rd_q[1]      <= s0_rd;
      index_q[1]   <= s0_index;
      is_mul_q[1]  <= (s0_op == ALU_MUL);
      illegal_q[1] <= s0_illegal;
      for (int k = 2; k <= LAST; k++) begin
        alu_q[k]     <= alu_q[k-1];
        mul_q[k]     <= mul_q[k-1];
        pc_q[k]      <= pc_q[k-1];
        rd_q[k]      <= rd_q[k-1];
        index_q[k]   <= index_q[k-1];
        is_mul_q[k]  <= is_mul_q[k-1];
        illegal_q[k] <= illegal_q[k-1];
      end
    end
  end

  assign res.valid     = valid_q[LAST];
  assign res.index     = index_q[LAST];
  assign res.rd        = rd_q[LAST];
  assign res.exception = illegal_q[LAST] ? ILLEGAL : NO_EXCEPTION;
  // illegal results report their pc
  assign res.wdata     = illegal_q[LAST] ? pc_q[LAST] :
                         is_mul_q[LAST]  ? mul_q[LAST] : alu_q[LAST];
  // x0 is never written
  assign res.wen       = ~illegal_q[LAST] & (rd_q[LAST] != '0);

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

  // datapath width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // accepted major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 variants
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_MUL  = 4'd10
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_insn_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_insn_t;

  // funct7 of the R view overlays imm[11:5] of the I view
  typedef union packed {
    r_insn_t r;
    i_insn_t i;
  } insn_u;

endpackage

// File: logic/exec_top.sv
`timescale 1ns/1ns

module exec_top
  import exec_pkg::*, cb_pkg::*;
#(
  parameter int NUM_LANES  = 2,
  parameter int LANE_DEPTH = 3
) (
  input  logic     CLK,
  input  logic     nRST,
  // issue port
  input  logic     in_valid,
  output logic     in_ready,
  input  word_t    in_insn,
  input  word_t    in_rs1,
  input  word_t    in_rs2,
  input  word_t    in_pc,
  input  reg_idx_t in_rd,
  input  cb_idx_t  in_index,
  // completion buffer writeback port
  output logic     wb_valid,
  input  logic     wb_ready,
  output cb_idx_t  wb_index,
  output reg_idx_t wb_rd,
  output word_t    wb_wdata,
  output logic     wb_wen,
  output exc_e     wb_exception
);

  issue_if  iss [NUM_LANES] ();
  result_if res [NUM_LANES] ();

  issue_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_insn  (in_insn),
    .in_rs1   (in_rs1),
    .in_rs2   (in_rs2),
    .in_pc    (in_pc),
    .in_rd    (in_rd),
    .in_index (in_index),
    .lanes    (iss)
  );

  // identical lanes, all of equal depth
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exec_lane #(
      .LANE_DEPTH (LANE_DEPTH)
    ) u_lane (
      .CLK  (CLK),
      .nRST (nRST),
      .iss  (iss[g]),
      .res  (res[g])
    );
  end

  wb_arbiter #(
    .NUM_LANES (NUM_LANES)
  ) u_arbiter (
    .CLK          (CLK),
    .nRST         (nRST),
    .lanes        (res),
    .wb_valid     (wb_valid),
    .wb_ready     (wb_ready),
    .wb_index     (wb_index),
    .wb_rd        (wb_rd),
    .wb_wdata     (wb_wdata),
    .wb_wen       (wb_wen),
    .wb_exception (wb_exception)
  );

endmodule

// File: logic/issue_dispatch.sv
`timescale 1ns/1ns

module issue_dispatch
  import exec_pkg::*, cb_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic      in_valid,
  output logic      in_ready,
  input  insn_u     in_insn,
  input  word_t     in_rs1,
  input  word_t     in_rs2,
  input  word_t     in_pc,
  input  reg_idx_t  in_rd,
  input  cb_idx_t   in_index,
  issue_if.dispatch lanes [NUM_LANES]
);

  logic [NUM_LANES-1:0] lane_ready;
  logic [NUM_LANES-1:0] lane_sel;
  alu_op_e              op;
  logic                 illegal;
  logic                 is_op;
  logic                 is_op_imm;
  word_t                imm_i;
  word_t                op_b;

  // funct3 map shared by OP and OP-IMM
  function automatic alu_op_e base_op(input logic [2:0] funct3);
    case (funct3)
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign is_op     = (in_insn.r.opcode == OPC_OP);
  assign is_op_imm = (in_insn.i.opcode == OPC_OP_IMM);
  assign imm_i     = {{(XLEN-12){in_insn.i.imm[11]}}, in_insn.i.imm};
  assign op_b      = is_op_imm ? imm_i : in_rs2;

  always_comb begin
    op      = base_op(in_insn.r.funct3);
    illegal = 1'b0;
    if (is_op) begin
      case (in_insn.r.funct7)
        F7_BASE: ;
        F7_ALT: begin
          if (in_insn.r.funct3 == 3'b000) begin
            op = ALU_SUB;
          end else if (in_insn.r.funct3 == 3'b101) begin
            op = ALU_SRA;
          end else begin
            illegal = 1'b1;
          end
        end
        F7_MULDIV: begin
          // only the low-word multiply
          op      = ALU_MUL;
          illegal = (in_insn.r.funct3 != 3'b000);
        end
        default: illegal = 1'b1;
      endcase
    end else if (is_op_imm) begin
      // shifts keep funct7 in the upper immediate bits
      if (in_insn.i.funct3 == 3'b001) begin
        illegal = (in_insn.r.funct7 != F7_BASE);
      end else if (in_insn.i.funct3 == 3'b101) begin
        if (in_insn.r.funct7 == F7_ALT) begin
          op = ALU_SRA;
        end else if (in_insn.r.funct7 != F7_BASE) begin
          illegal = 1'b1;
        end
      end
    end else begin
      illegal = 1'b1;
    end
    if (illegal) begin
      op = ALU_ADD;
    end
  end

  // lowest ready lane takes the operation
  always_comb begin
    logic found;
    found    = 1'b0;
    lane_sel = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_ready[i] && !found) begin
        lane_sel[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign in_ready = |lane_ready;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_ready[g]    = lanes[g].ready;
    assign lanes[g].valid   = in_valid & lane_sel[g];
    assign lanes[g].op      = op;
    assign lanes[g].op_a    = in_rs1;
    assign lanes[g].op_b    = op_b;
    assign lanes[g].pc      = in_pc;
    assign lanes[g].rd      = in_rd;
    assign lanes[g].index   = in_index;
    assign lanes[g].illegal = illegal;
  end

endmodule

// File: logic/issue_if.sv
`timescale 1ns/1ns

interface issue_if
  import exec_pkg::*, cb_pkg::*;
();

  logic     valid;
  logic     ready;
  alu_op_e  op;
  word_t    op_a;
  word_t    op_b;
  word_t    pc;
  reg_idx_t rd;
  cb_idx_t  index;
  // encoding not supported, leaves as an exception
  logic     illegal;

  modport dispatch (
    output valid, op, op_a, op_b, pc, rd, index, illegal,
    input  ready
  );

  modport lane (
    input  valid, op, op_a, op_b, pc, rd, index, illegal,
    output ready
  );

endinterface

// File: logic/result_if.sv
`timescale 1ns/1ns

interface result_if
  import exec_pkg::*, cb_pkg::*;
();

  logic     valid;
  logic     grant;
  cb_idx_t  index;
  reg_idx_t rd;
  word_t    wdata;
  logic     wen;
  exc_e     exception;

  modport lane (
    output valid, index, rd, wdata, wen, exception,
    input  grant
  );

  modport arbiter (
    input  valid, index, rd, wdata, wen, exception,
    output grant
  );

endinterface

// File: logic/wb_arbiter.sv
`timescale 1ns/1ns

module wb_arbiter
  import exec_pkg::*, cb_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic      CLK,
  input  logic      nRST,
  result_if.arbiter lanes [NUM_LANES],
  output logic      wb_valid,
  input  logic      wb_ready,
  output cb_idx_t   wb_index,
  output reg_idx_t  wb_rd,
  output word_t     wb_wdata,
  output logic      wb_wen,
  output exc_e      wb_exception
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [NUM_LANES-1:0] lane_valid;
  logic [NUM_LANES-1:0] lane_wen;
  cb_idx_t              lane_index [NUM_LANES];
  reg_idx_t             lane_rd    [NUM_LANES];
  word_t                lane_wdata [NUM_LANES];
  exc_e                 lane_exc   [NUM_LANES];
  logic [PTR_W-1:0]     ptr;
  logic [PTR_W-1:0]     sel;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_valid[g]  = lanes[g].valid;
    assign lane_wen[g]    = lanes[g].wen;
    assign lane_index[g]  = lanes[g].index;
    assign lane_rd[g]     = lanes[g].rd;
    assign lane_wdata[g]  = lanes[g].wdata;
    assign lane_exc[g]    = lanes[g].exception;
    assign lanes[g].grant = wb_ready & lane_valid[g] & (sel == PTR_W'(g));
  end

  // first valid lane at or after the pointer
  always_comb begin
    int cand;
    sel = ptr;
    for (int k = NUM_LANES - 1; k >= 0; k--) begin
      cand = (int'(ptr) + k) % NUM_LANES;
      if (lane_valid[cand]) begin
        sel = PTR_W'(cand);
      end
    end
  end

  assign wb_valid     = |lane_valid;
  assign wb_index     = lane_index[sel];
  assign wb_rd        = lane_rd[sel];
  assign wb_wdata     = lane_wdata[sel];
  assign wb_wen       = lane_wen[sel];
  assign wb_exception = lane_exc[sel];

  // parking on the stalled lane keeps its payload on the port
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ptr <= '0;
    end else if (wb_valid) begin
      if (wb_ready) begin
        ptr <= (sel == PTR_W'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
      end else begin
        ptr <= sel;
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_exec \
    -f src.f -o sim_exec; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_exec 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: src.f
logic/exec_pkg.sv
logic/cb_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/issue_dispatch.sv
logic/exec_lane.sv
logic/wb_arbiter.sv
logic/exec_top.sv
bench/tb_clock.sv
bench/exec_properties.sv
bench/tb_exec.sv
